// ==== verilog/ddr_sim_pkg.sv ====
package ddr_sim_pkg;

  // Data word of the memory port and the APB bus
  typedef logic [31:0] word_t;
  // One enable per byte lane
  typedef logic [3:0] strb_t;
  // APB register offset, byte address
  typedef logic [7:0] apb_addr_t;

  // Address window given to the memory port
  typedef struct packed {
    word_t addr_start;
    word_t addr_end;
  } mapinfo_t;

  // Plug-and-play descriptor of the memory slave
  typedef struct packed {
    logic [1:0]  descrtype;
    word_t       addr_start;
    word_t       addr_end;
    logic [15:0] vid;
    logic [15:0] did;
  } dev_config_t;

  // Single memory request, one strobe per request
  typedef struct packed {
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
    strb_t wstrb;
  } mem_req_t;

  // Memory response, always two cycles after the request
  typedef struct packed {
    logic  valid;
    logic  err;
    word_t rdata;
  } mem_rsp_t;

  // APB requester side
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
  } apb_in_t;

  // APB completer side
  typedef struct packed {
    logic  pready;
    logic  pslverr;
    word_t prdata;
  } apb_out_t;

  // Controller state seen by the register block
  typedef struct packed {
    logic        calib_done;
    logic        busy;
    logic [15:0] ref_count;
  } ctrl_status_t;

  // Register map
  localparam apb_addr_t REG_STATUS  = 8'h00;
  localparam apb_addr_t REG_TEMP    = 8'h04;
  localparam apb_addr_t REG_CTRL    = 8'h08;
  localparam apb_addr_t REG_SCRATCH = 8'h0C;

  // Device descriptor constants
  localparam logic [1:0]  CFG_TYPE_SLAVE = 2'd2;
  localparam logic [15:0] VENDOR_ID      = 16'h00F1;
  localparam logic [15:0] SRAM_DEV_ID    = 16'h0073;

endpackage

// ==== verilog/ddr_ctrl.sv ====
module ddr_ctrl #(
  parameter int CALIB_CYCLES = 16,
  parameter int REF_CYCLES   = 8
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_ref_req,
  output ddr_sim_pkg::ctrl_status_t o_status,
  output logic                      o_mem_avail,
  output logic                      o_init_calib_done
);

  localparam int CAL_W = $clog2(CALIB_CYCLES + 1);
  localparam int REF_W = $clog2(REF_CYCLES + 1);

  logic [CAL_W-1:0] cal_cnt;
  logic             calib_done;
  logic [REF_W-1:0] ref_cnt;
  logic             busy;
  logic [15:0]      ref_count;
  logic             ref_start;
  logic             ref_last;

  // Refresh only from idle and after calibration, else the request is lost
  assign ref_start = i_ref_req && calib_done && !busy;
  // Final busy cycle of the current refresh
  assign ref_last  = busy && (ref_cnt == REF_W'(REF_CYCLES - 1));

  // Start-up calibration model
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cal_cnt    <= '0;
      calib_done <= 1'b0;
    end else if (!calib_done) begin
      // Done flag rises CALIB_CYCLES edges after reset release
      if (cal_cnt == CAL_W'(CALIB_CYCLES - 1)) begin
        calib_done <= 1'b1;
      end
      cal_cnt <= cal_cnt + 1'b1;
    end
  end

  // Refresh sequencer
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy      <= 1'b0;
      ref_cnt   <= '0;
      ref_count <= '0;
    end else if (ref_start) begin
      busy    <= 1'b1;
      ref_cnt <= '0;
    end else if (busy) begin
      if (ref_last) begin
        busy      <= 1'b0;
        // Count completed refreshes on the falling edge of busy
        ref_count <= ref_count + 16'd1;
      end
      ref_cnt <= ref_cnt + 1'b1;
    end
  end

  assign o_status.calib_done = calib_done;
  assign o_status.busy       = busy;
  assign o_status.ref_count  = ref_count;

  // Memory usable only when calibrated and not refreshing
  assign o_mem_avail       = calib_done && !busy;
  assign o_init_calib_done = calib_done;

endmodule

// ==== verilog/apb_ddr_regs.sv ====
module apb_ddr_regs #(
  parameter logic [11:0] DEVICE_TEMP = 12'h456
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  ddr_sim_pkg::apb_in_t      i_apb,
  output ddr_sim_pkg::apb_out_t     o_apb,
  input  ddr_sim_pkg::ctrl_status_t i_status,
  output logic                      o_ref_req
);

  logic               access;
  logic               wr_access;
  logic               rd_access;
  logic               mapped;
  ddr_sim_pkg::word_t rdata;
  ddr_sim_pkg::word_t scratch;

  // Access phase of a transfer, no wait states
  assign access    = i_apb.psel && i_apb.penable;
  assign wr_access = access && i_apb.pwrite;
  assign rd_access = access && !i_apb.pwrite;

  // Offset decode and read mux
  always_comb begin
    mapped = 1'b1;
    rdata  = '0;
    case (i_apb.paddr)
      ddr_sim_pkg::REG_STATUS: begin
        // Count in the upper half, flags in the low bits
        rdata = {i_status.ref_count, 14'd0, i_status.busy, i_status.calib_done};
      end
      ddr_sim_pkg::REG_TEMP: begin
        rdata = {20'd0, DEVICE_TEMP};
      end
      ddr_sim_pkg::REG_CTRL: begin
        // Pulse register, nothing stored
        rdata = '0;
      end
      ddr_sim_pkg::REG_SCRATCH: begin
        rdata = scratch;
      end
      default: begin
        mapped = 1'b0;
      end
    endcase
  end

  // Scratch register, software read/write
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      scratch <= '0;
    end else if (wr_access && (i_apb.paddr == ddr_sim_pkg::REG_SCRATCH)) begin
      scratch <= i_apb.pwdata;
    end
  end

  // Write one to CTRL bit 0 requests a refresh in the same cycle
  assign o_ref_req = wr_access && (i_apb.paddr == ddr_sim_pkg::REG_CTRL) &&
                     i_apb.pwdata[0];

  // Status and temperature writes fall through the decode silently
  assign o_apb.pready  = access;
  assign o_apb.pslverr = access && !mapped;
  assign o_apb.prdata  = rd_access ? rdata : '0;

endmodule

// ==== verilog/mem_port.sv ====
module mem_port #(
  parameter int ABITS = 10
) (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  ddr_sim_pkg::mapinfo_t    i_mapinfo,
  output ddr_sim_pkg::dev_config_t o_cfg,
  input  ddr_sim_pkg::mem_req_t    i_req,
  output ddr_sim_pkg::mem_rsp_t    o_rsp,
  input  logic                     i_mem_avail,
  output logic                     o_wr_en,
  output logic [ABITS-1:0]         o_word_addr,
  output logic [31:0]              o_wdata,
  output logic [3:0]               o_wstrb,
  input  logic [31:0]              i_rdata
);

  logic               in_range;
  logic               accept;
  ddr_sim_pkg::word_t offset;
  logic               s1_valid;
  logic               s1_err;
  logic               s1_read;
  logic               rsp_valid;
  logic               rsp_err;
  ddr_sim_pkg::word_t rsp_rdata;

  // Window includes addr_start and excludes addr_end
  assign in_range = (i_req.addr >= i_mapinfo.addr_start) &&
                    (i_req.addr < i_mapinfo.addr_end);
  assign accept   = in_range && i_mem_avail;

  // Byte offset into the window, then word index
  assign offset      = i_req.addr - i_mapinfo.addr_start;
  assign o_word_addr = offset[ABITS+1:2];

  // Array write happens in the request cycle, only when accepted
  assign o_wr_en = i_req.valid && i_req.write && accept;
  assign o_wdata = i_req.wdata;
  assign o_wstrb = i_req.wstrb;

  // Stage 1 lines up with the registered array read
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_valid  <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      s1_valid  <= i_req.valid;
      rsp_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    s1_err  <= !accept;
    s1_read <= !i_req.write;
    rsp_err <= s1_err;
    // Data only for an accepted read, zero otherwise
    rsp_rdata <= (s1_valid && s1_read && !s1_err) ? i_rdata : '0;
  end

  assign o_rsp.valid = rsp_valid;
  assign o_rsp.err   = rsp_err;
  assign o_rsp.rdata = rsp_rdata;

  // Device descriptor from the given window
  assign o_cfg.descrtype  = ddr_sim_pkg::CFG_TYPE_SLAVE;
  assign o_cfg.addr_start = i_mapinfo.addr_start;
  assign o_cfg.addr_end   = i_mapinfo.addr_end;
  assign o_cfg.vid        = ddr_sim_pkg::VENDOR_ID;
  assign o_cfg.did        = ddr_sim_pkg::SRAM_DEV_ID;

endmodule

// ==== verilog/sram_array.sv ====
module sram_array #(
  parameter int ABITS = 10
) (
  input  logic             i_clk,
  input  logic             i_wr_en,
  input  logic [ABITS-1:0] i_word_addr,
  input  logic [31:0]      i_wdata,
  input  logic [3:0]       i_wstrb,
  output logic [31:0]      o_rdata
);

  // Storage, contents unknown until written
  logic [31:0] mem [2**ABITS];
  logic [31:0] rdata_q;

  // Byte-lane writes
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (i_wstrb[b]) begin
          mem[i_word_addr][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // Registered read, old data when the same word is written this cycle
  always_ff @(posedge i_clk) begin
    rdata_q <= mem[i_word_addr];
  end

  assign o_rdata = rdata_q;

endmodule

// ==== verilog/ddr_sim_top.sv ====
module ddr_sim_top #(
  parameter int          ABITS        = 10,
  parameter int          CALIB_CYCLES = 16,
  parameter int          REF_CYCLES   = 8,
  parameter logic [11:0] DEVICE_TEMP  = 12'h456
) (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  ddr_sim_pkg::mapinfo_t    i_mapinfo,
  output ddr_sim_pkg::dev_config_t o_cfg,
  input  ddr_sim_pkg::mem_req_t    i_mem_req,
  output ddr_sim_pkg::mem_rsp_t    o_mem_rsp,
  input  ddr_sim_pkg::apb_in_t     i_apb,
  output ddr_sim_pkg::apb_out_t    o_apb,
  output logic                     o_init_calib_done
);

  ddr_sim_pkg::ctrl_status_t ctrl_status;
  logic                      ref_req;
  logic                      mem_avail;
  logic                      wr_en;
  logic [ABITS-1:0]          word_addr;
  logic [31:0]               wdata;
  logic [3:0]                wstrb;
  logic [31:0]               rdata;

  // Calibration and refresh model
  ddr_ctrl #(
    .CALIB_CYCLES(CALIB_CYCLES),
    .REF_CYCLES  (REF_CYCLES)
  ) u_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_ref_req        (ref_req),
    .o_status         (ctrl_status),
    .o_mem_avail      (mem_avail),
    .o_init_calib_done(o_init_calib_done)
  );

  // APB control and status registers
  apb_ddr_regs #(
    .DEVICE_TEMP(DEVICE_TEMP)
  ) u_regs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_apb    (i_apb),
    .o_apb    (o_apb),
    .i_status (ctrl_status),
    .o_ref_req(ref_req)
  );

  // Request decode and response pipeline
  mem_port #(
    .ABITS(ABITS)
  ) u_port (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_mapinfo  (i_mapinfo),
    .o_cfg      (o_cfg),
    .i_req      (i_mem_req),
    .o_rsp      (o_mem_rsp),
    .i_mem_avail(mem_avail),
    .o_wr_en    (wr_en),
    .o_word_addr(word_addr),
    .o_wdata    (wdata),
    .o_wstrb    (wstrb),
    .i_rdata    (rdata)
  );

  // Backing store
  sram_array #(
    .ABITS(ABITS)
  ) u_sram (
    .i_clk      (i_clk),
    .i_wr_en    (wr_en),
    .i_word_addr(word_addr),
    .i_wdata    (wdata),
    .i_wstrb    (wstrb),
    .o_rdata    (rdata)
  );

endmodule

// ==== tests/ddr_sim_assertions.sv ====
module ddr_sim_assertions #(
  parameter int REF_CYCLES = 8
) (
  input logic                  i_clk,
  input logic                  i_rst_n,
  input ddr_sim_pkg::mem_req_t i_mem_req,
  input ddr_sim_pkg::mem_rsp_t o_mem_rsp,
  input ddr_sim_pkg::apb_in_t  i_apb,
  input ddr_sim_pkg::apb_out_t o_apb,
  input logic                  o_init_calib_done,
  input logic                  i_busy
);

  // Length of the current busy run
  int busy_len;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy_len <= 0;
    end else if (i_busy) begin
      busy_len <= busy_len + 1;
    end else begin
      busy_len <= 0;
    end
  end

  // Response strobe two cycles after the request strobe
  a_rsp_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_mem_rsp.valid == $past(i_mem_req.valid, 2))
    else $error("response strobe not two cycles after request");

  // Calibration done is sticky
  a_calib_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_init_calib_done |=> o_init_calib_done)
    else $error("calibration done fell");

  // No wait states on APB
  a_pready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_apb.psel && i_apb.penable) |-> o_apb.pready)
    else $error("pready low in access phase");

  // Each refresh holds busy for exactly REF_CYCLES
  a_busy_len: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $fell(i_busy) |-> (busy_len == REF_CYCLES))
    else $error("refresh busy length wrong");

endmodule

// ==== tests/tb_ddr_sim.sv ====
module tb_ddr_sim;

  // Stimulus kinds
  localparam logic [1:0] K_MWR = 2'd0;
  localparam logic [1:0] K_MRD = 2'd1;
  localparam logic [1:0] K_AWR = 2'd2;
  localparam logic [1:0] K_ARD = 2'd3;
  localparam int RSP_LAT = 2;
  localparam int WAIT_MAX = 100;
  localparam logic [31:0] WIN_START = 32'h8000_0000;
  localparam logic [31:0] WIN_END   = 32'h8000_1000;

  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp_data;
    logic        exp_err;
  } stim_t;

  logic                     clk;
  logic                     i_rst_n;
  ddr_sim_pkg::mapinfo_t    i_mapinfo;
  ddr_sim_pkg::dev_config_t o_cfg;
  ddr_sim_pkg::mem_req_t    i_mem_req;
  ddr_sim_pkg::mem_rsp_t    o_mem_rsp;
  ddr_sim_pkg::apb_in_t     i_apb;
  ddr_sim_pkg::apb_out_t    o_apb;
  logic                     o_init_calib_done;

  stim_t       table_q[$];
  // Byte-level model of the memory contents
  logic [7:0]  shadow [logic [31:0]];
  int          n_checks;
  int          n_errors;
  int          err_mark;
  string       cur_test;

  ddr_sim_top DUT (
    .i_clk            (clk),
    .i_rst_n          (i_rst_n),
    .i_mapinfo        (i_mapinfo),
    .o_cfg            (o_cfg),
    .i_mem_req        (i_mem_req),
    .o_mem_rsp        (o_mem_rsp),
    .i_apb            (i_apb),
    .o_apb            (o_apb),
    .o_init_calib_done(o_init_calib_done)
  );

  bind ddr_sim_top ddr_sim_assertions #(.REF_CYCLES(REF_CYCLES)) u_assertions (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_mem_req        (i_mem_req),
    .o_mem_rsp        (o_mem_rsp),
    .i_apb            (i_apb),
    .o_apb            (o_apb),
    .o_init_calib_done(o_init_calib_done),
    .i_busy           (ctrl_status.busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Ends the run when the DUT never answers
  task automatic abort_run(input string why);
    $display("timeout: %s at time %0t", why, $time);
    $display("sim failed");
    $finish;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = n_errors;
  endtask

  task automatic finish_test();
    if (n_errors == err_mark) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: FAIL (%0d errors)", cur_test, n_errors - err_mark);
    end
  endtask

  task automatic check_mem_rsp(input string what, input ddr_sim_pkg::mem_rsp_t got,
                               input ddr_sim_pkg::mem_rsp_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR t=%0t %s: mem rsp valid=%b err=%b rdata=%h, want valid=%b err=%b rdata=%h",
               $time, what, got.valid, got.err, got.rdata, exp.valid, exp.err, exp.rdata);
    end
  endtask

  task automatic check_apb_rsp(input string what, input ddr_sim_pkg::apb_out_t got,
                               input ddr_sim_pkg::apb_out_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR t=%0t %s: apb pready=%b pslverr=%b prdata=%h, want %b %b %h",
               $time, what, got.pready, got.pslverr, got.prdata,
               exp.pready, exp.pslverr, exp.prdata);
    end
  endtask

  task automatic check_cfg(input ddr_sim_pkg::dev_config_t got,
                           input ddr_sim_pkg::dev_config_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR t=%0t device config %h, want %h", $time, got, exp);
    end
  endtask

  // Single-bit status outputs of the top level
  task automatic check_flag(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR t=%0t %s: %b, want %b", $time, what, got, exp);
    end
  endtask

  // Only enabled byte lanes change
  task automatic shadow_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        shadow[addr + 32'(b)] = data[8*b +: 8];
      end
    end
  endtask

  function automatic logic [31:0] shadow_read(input logic [31:0] addr);
    logic [31:0] w;
    w = 'x;
    for (int b = 0; b < 4; b++) begin
      if (shadow.exists(addr + 32'(b))) begin
        w[8*b +: 8] = shadow[addr + 32'(b)];
      end
    end
    return w;
  endfunction

  // One request strobe followed by a wait for the response and its latency
  task automatic mem_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output ddr_sim_pkg::mem_rsp_t rsp);
    int lat;
    @(posedge clk);
    i_mem_req.valid <= 1'b1;
    i_mem_req.write <= wr;
    i_mem_req.addr  <= addr;
    i_mem_req.wdata <= data;
    i_mem_req.wstrb <= strb;
    @(posedge clk);
    i_mem_req.valid <= 1'b0;
    lat = 0;
    // Sampled mid-cycle
    // lat counts cycles after the request cycle
    while (1) begin
      @(negedge clk);
      lat++;
      if (o_mem_rsp.valid) begin
        break;
      end
      if (lat > WAIT_MAX) begin
        abort_run("no memory response");
      end
    end
    rsp = o_mem_rsp;
    n_checks++;
    if (lat != RSP_LAT) begin
      n_errors++;
      $display("ERR t=%0t response latency %0d, want %0d", $time, lat, RSP_LAT);
    end
  endtask

  // Setup phase, access phase, then idle
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output ddr_sim_pkg::apb_out_t rsp);
    int n;
    @(posedge clk);
    i_apb.psel    <= 1'b1;
    i_apb.penable <= 1'b0;
    i_apb.pwrite  <= wr;
    i_apb.paddr   <= addr;
    i_apb.pwdata  <= data;
    @(posedge clk);
    i_apb.penable <= 1'b1;
    n = 0;
    while (1) begin
      @(negedge clk);
      n++;
      if (o_apb.pready) begin
        break;
      end
      if (n > WAIT_MAX) begin
        abort_run("APB pready never rose");
      end
    end
    rsp = o_apb;
    @(posedge clk);
    i_apb.psel    <= 1'b0;
    i_apb.penable <= 1'b0;
  endtask

  task automatic add_stim(input logic [1:0] kind, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] strb,
                          input logic [31:0] exp_data, input logic exp_err);
    stim_t s;
    s.kind     = kind;
    s.addr     = addr;
    s.data     = data;
    s.strb     = strb;
    s.exp_data = exp_data;
    s.exp_err  = exp_err;
    table_q.push_back(s);
  endtask

  // Applies and empties the table
  task automatic run_table();
    ddr_sim_pkg::mem_rsp_t mrsp;
    ddr_sim_pkg::mem_rsp_t mexp;
    ddr_sim_pkg::apb_out_t arsp;
    ddr_sim_pkg::apb_out_t aexp;
    foreach (table_q[i]) begin
      if (table_q[i].kind == K_MWR || table_q[i].kind == K_MRD) begin
        mem_access(table_q[i].kind == K_MWR, table_q[i].addr, table_q[i].data,
                   table_q[i].strb, mrsp);
        mexp.valid = 1'b1;
        mexp.err   = table_q[i].exp_err;
        mexp.rdata = '0;
        // Accepted reads return the modeled bytes
        if (table_q[i].kind == K_MRD && !table_q[i].exp_err) begin
          mexp.rdata = shadow_read(table_q[i].addr);
        end
        check_mem_rsp($sformatf("entry %0d", i), mrsp, mexp);
        // Rejected writes leave the model untouched
        if (table_q[i].kind == K_MWR && !table_q[i].exp_err) begin
          shadow_write(table_q[i].addr, table_q[i].data, table_q[i].strb);
        end
      end else begin
        apb_access(table_q[i].kind == K_AWR, table_q[i].addr[7:0], table_q[i].data, arsp);
        aexp.pready  = 1'b1;
        aexp.pslverr = table_q[i].exp_err;
        aexp.prdata  = (table_q[i].kind == K_ARD) ? table_q[i].exp_data : '0;
        check_apb_rsp($sformatf("entry %0d", i), arsp, aexp);
      end
    end
    table_q.delete();
  endtask

  initial begin
    ddr_sim_pkg::mem_rsp_t    mrsp;
    ddr_sim_pkg::mem_rsp_t    mexp;
    ddr_sim_pkg::apb_out_t    arsp;
    ddr_sim_pkg::dev_config_t cexp;
    logic [31:0]              wd;
    int                       n;
    void'($urandom(38135));
    n_checks           = 0;
    n_errors           = 0;
    i_rst_n            = 1'b0;
    i_mapinfo.addr_start = WIN_START;
    i_mapinfo.addr_end   = WIN_END;
    i_mem_req          = '0;
    i_apb              = '0;
    repeat (3) @(posedge clk);
    i_rst_n <= 1'b1;

    start_test("calibration");
    // Nothing pending and calibration not yet done right after reset
    @(negedge clk);
    check_flag("calibration done after reset", o_init_calib_done, 1'b0);
    check_flag("response strobe after reset", o_mem_rsp.valid, 1'b0);
    // Port refuses requests while still calibrating
    mem_access(1'b0, WIN_START, 32'h0, 4'hF, mrsp);
    mexp = '{valid: 1'b1, err: 1'b1, rdata: 32'h0};
    check_mem_rsp("request before calibration", mrsp, mexp);
    n = 0;
    while (!o_init_calib_done) begin
      @(negedge clk);
      n++;
      if (n > WAIT_MAX) begin
        abort_run("calibration never completed");
      end
    end
    apb_access(1'b0, ddr_sim_pkg::REG_STATUS, 32'h0, arsp);
    check_apb_rsp("status after calibration", arsp,
                  '{pready: 1'b1, pslverr: 1'b0, prdata: 32'h1});
    finish_test();

    start_test("memory read/write");
    // Full and partial strobes at both ends and in the middle of the window
    add_stim(K_MWR, WIN_START, $urandom(), 4'hF, '0, 1'b0);
    add_stim(K_MRD, WIN_START, '0, '0, '0, 1'b0);
    add_stim(K_MWR, WIN_START, $urandom(), 4'b0101, '0, 1'b0);
    add_stim(K_MRD, WIN_START, '0, '0, '0, 1'b0);
    add_stim(K_MWR, WIN_END - 32'd4, $urandom(), 4'hF, '0, 1'b0);
    add_stim(K_MWR, WIN_END - 32'd4, $urandom(), 4'b1000, '0, 1'b0);
    add_stim(K_MRD, WIN_END - 32'd4, '0, '0, '0, 1'b0);
    add_stim(K_MWR, WIN_START + 32'h404, $urandom(), 4'hF, '0, 1'b0);
    add_stim(K_MWR, WIN_START + 32'h404, $urandom(), 4'b0110, '0, 1'b0);
    add_stim(K_MRD, WIN_START + 32'h404, '0, '0, '0, 1'b0);
    run_table();
    // Write then read of the same word in consecutive cycles
    wd = $urandom();
    @(posedge clk);
    i_mem_req <= '{valid: 1'b1, write: 1'b1, addr: WIN_START + 32'h20, wdata: wd,
                   wstrb: 4'hF};
    @(posedge clk);
    i_mem_req <= '{valid: 1'b1, write: 1'b0, addr: WIN_START + 32'h20, wdata: 32'h0,
                   wstrb: 4'h0};
    @(posedge clk);
    i_mem_req.valid <= 1'b0;
    shadow_write(WIN_START + 32'h20, wd, 4'hF);
    n = 0;
    while (1) begin
      @(negedge clk);
      n++;
      if (o_mem_rsp.valid) begin
        break;
      end
      if (n > WAIT_MAX) begin
        abort_run("no response to back-to-back write");
      end
    end
    check_mem_rsp("back-to-back write", o_mem_rsp, '{valid: 1'b1, err: 1'b0, rdata: 32'h0});
    // Read response follows in the very next cycle
    @(negedge clk);
    mexp = '{valid: 1'b1, err: 1'b0, rdata: shadow_read(WIN_START + 32'h20)};
    check_mem_rsp("read right after write", o_mem_rsp, mexp);
    finish_test();

    start_test("address window");
    // Out-of-window writes alias onto words that are read back afterwards
    add_stim(K_MWR, WIN_START - 32'd4, $urandom(), 4'hF, '0, 1'b1);
    add_stim(K_MWR, WIN_END, $urandom(), 4'hF, '0, 1'b1);
    add_stim(K_MWR, 32'hFFFF_FFF0, $urandom(), 4'hF, '0, 1'b1);
    add_stim(K_MRD, WIN_END, '0, '0, '0, 1'b1);
    add_stim(K_MRD, WIN_START, '0, '0, '0, 1'b0);
    add_stim(K_MRD, WIN_END - 32'd4, '0, '0, '0, 1'b0);
    run_table();
    finish_test();

    start_test("registers");
    add_stim(K_AWR, 32'(ddr_sim_pkg::REG_SCRATCH), 32'hA5A5_5A5A, '0, '0, 1'b0);
    add_stim(K_ARD, 32'(ddr_sim_pkg::REG_SCRATCH), '0, '0, 32'hA5A5_5A5A, 1'b0);
    add_stim(K_AWR, 32'(ddr_sim_pkg::REG_TEMP), 32'h0, '0, '0, 1'b0);
    add_stim(K_ARD, 32'(ddr_sim_pkg::REG_TEMP), '0, '0, 32'h0000_0456, 1'b0);
    add_stim(K_AWR, 32'(ddr_sim_pkg::REG_STATUS), 32'hFFFF_FFFF, '0, '0, 1'b0);
    add_stim(K_ARD, 32'(ddr_sim_pkg::REG_STATUS), '0, '0, 32'h0000_0001, 1'b0);
    add_stim(K_ARD, 32'h10, '0, '0, 32'h0, 1'b1);
    add_stim(K_AWR, 32'h14, 32'h1234_5678, '0, '0, 1'b1);
    run_table();
    finish_test();

    start_test("refresh");
    // No refresh has run yet, counter still zero
    apb_access(1'b0, ddr_sim_pkg::REG_STATUS, 32'h0, arsp);
    check_apb_rsp("status before refresh", arsp,
                  '{pready: 1'b1, pslverr: 1'b0, prdata: 32'h0000_0001});
    apb_access(1'b1, ddr_sim_pkg::REG_CTRL, 32'h1, arsp);
    check_apb_rsp("refresh request", arsp, '{pready: 1'b1, pslverr: 1'b0, prdata: 32'h0});
    // Memory unavailable while the refresh runs
    mem_access(1'b0, WIN_START, 32'h0, 4'h0, mrsp);
    check_mem_rsp("request during refresh", mrsp, '{valid: 1'b1, err: 1'b1, rdata: 32'h0});
    n = 0;
    while (1) begin
      apb_access(1'b0, ddr_sim_pkg::REG_STATUS, 32'h0, arsp);
      if (!arsp.prdata[1]) begin
        break;
      end
      n++;
      if (n > WAIT_MAX) begin
        abort_run("refresh never finished");
      end
    end
    // One completed refresh in the upper half
    check_apb_rsp("status after refresh", arsp,
                  '{pready: 1'b1, pslverr: 1'b0, prdata: 32'h0001_0001});
    add_stim(K_MWR, WIN_START + 32'h40, $urandom(), 4'hF, '0, 1'b0);
    add_stim(K_MRD, WIN_START + 32'h40, '0, '0, '0, 1'b0);
    run_table();
    finish_test();

    start_test("device config");
    cexp.descrtype  = ddr_sim_pkg::CFG_TYPE_SLAVE;
    cexp.addr_start = WIN_START;
    cexp.addr_end   = WIN_END;
    cexp.vid        = ddr_sim_pkg::VENDOR_ID;
    cexp.did        = ddr_sim_pkg::SRAM_DEV_ID;
    check_cfg(o_cfg, cexp);
    finish_test();

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
verilog/ddr_sim_pkg.sv
verilog/ddr_ctrl.sv
verilog/apb_ddr_regs.sv
verilog/mem_port.sv
verilog/sram_array.sv
verilog/ddr_sim_top.sv
tests/ddr_sim_assertions.sv
tests/tb_ddr_sim.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ddr_sim -f build.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
